// File: logic/lsu_types_pkg.sv
// core-side access description for the load/store unit
// access size encoding, byte offset type, FSM states and split check

package lsu_types_pkg;

  // size encoding from the execute stage, 2'b10 and 2'b11 both select a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } access_size_e;

  typedef logic [1:0] byte_offset_t;  // low address bits, byte lane inside a word

  // bus sequencing states
  typedef enum logic [2:0] {
    LS_IDLE,             // no access in flight
    LS_WAIT_GNT_MIS,     // split access, first part not yet granted
    LS_WAIT_RVALID_MIS,  // first part granted, second part being requested
    LS_WAIT_GNT,         // last (or only) part waiting for grant
    LS_WAIT_RVALID,      // last (or only) part waiting for response
    LS_WAIT_RVALID_DONE  // second part granted, first response still due
  } ls_state_e;

  // an access crossing a word boundary needs two bus transactions
  function automatic logic is_split(access_size_e size, byte_offset_t offset);
    logic word_split;
    logic half_split;
    word_split = (size == SIZE_WORD) && (offset != 2'b00);
    half_split = (size == SIZE_HALF) && (offset == 2'b11);
    return word_split || half_split;
  endfunction

endpackage

// File: logic/mem_bus_pkg.sv
// memory bus constants and types
// data/address width, byte enables, word step

package mem_bus_pkg;

  localparam int BUS_WIDTH      = 32;  // data and address width
  localparam int BYTES_PER_WORD = 4;
  localparam int WORD_STRIDE    = 4;   // address step to the next bus word

  typedef logic [BYTES_PER_WORD-1:0] be_t;    // one enable per byte lane
  typedef logic [BUS_WIDTH-1:0]      bus_word_t;

endpackage

// File: logic/lsu_ctrl_if.sv
// control strobes between the LSU FSM and the request / response datapaths

`timescale 1ns/10ps

interface lsu_ctrl_if;

  logic split_access;  // current access crosses a word boundary
  logic second_part;   // request path presents the upper word
  logic ctrl_update;   // capture offset, size and sign flag
  logic rdata_update;  // keep first-part response bytes

  // sequencing side
  modport fsm (
    input  split_access,
    output second_part,
    output ctrl_update,
    output rdata_update
  );

  // address, byte enable and write data side
  modport req (
    output split_access,
    input  second_part
  );

  // load data side, only needs the capture strobes
  modport rdata (
    input  ctrl_update,
    input  rdata_update
  );

endinterface

// File: logic/lsu_fsm.sv
// LSU bus sequencing FSM
// single and split transactions, overlapped second grant, error merging

`timescale 1ns/10ps

module lsu_fsm import lsu_types_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic req_i,  // access pending from execute stage
  input  logic we_i,

  input  logic mem_gnt_i,
  input  logic mem_rvalid_i,
  input  logic mem_err_i,

  output logic mem_req_o,
  output logic valid_o,
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o,

  lsu_ctrl_if.fsm ctrl
);

  ls_state_e state_q, state_d;

  logic second_part_q, second_part_d;  // high from first grant of a split access
  logic lsu_err_q, lsu_err_d;          // error seen on first part
  logic we_q;                          // direction of the access in flight
  logic resp_err;                      // merged error on completion

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    second_part_d = second_part_q;
    lsu_err_d     = lsu_err_q;

    mem_req_o         = 1'b0;
    valid_o           = 1'b0;
    resp_err          = 1'b0;
    ctrl.ctrl_update  = 1'b0;
    ctrl.rdata_update = 1'b0;

    unique case (state_q)
      LS_IDLE: begin
        if (req_i) begin
          mem_req_o = 1'b1;
          lsu_err_d = 1'b0;  // fresh access
          if (mem_gnt_i) begin
            ctrl.ctrl_update = 1'b1;
            second_part_d    = ctrl.split_access;
            state_d = ctrl.split_access ? LS_WAIT_RVALID_MIS : LS_WAIT_RVALID;
          end else begin
            state_d = ctrl.split_access ? LS_WAIT_GNT_MIS : LS_WAIT_GNT;
          end
        end
      end

      LS_WAIT_GNT_MIS: begin
        mem_req_o = 1'b1;  // first part held until granted
        if (mem_gnt_i) begin
          ctrl.ctrl_update = 1'b1;
          second_part_d    = 1'b1;
          state_d          = LS_WAIT_RVALID_MIS;
        end
      end

      LS_WAIT_RVALID_MIS: begin
        mem_req_o = 1'b1;  // second part goes out while first is outstanding
        if (mem_rvalid_i) begin
          lsu_err_d         = mem_err_i;
          ctrl.rdata_update = ~we_q;  // only loads need the low-word bytes
          state_d = mem_gnt_i ? LS_WAIT_RVALID : LS_WAIT_GNT;
        end else if (mem_gnt_i) begin
          state_d = LS_WAIT_RVALID_DONE;  // both parts now outstanding
        end
      end

      LS_WAIT_GNT: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          // offset etc. already captured if this is the second part
          ctrl.ctrl_update = ~second_part_q;
          state_d          = LS_WAIT_RVALID;
        end
      end

      LS_WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          valid_o       = 1'b1;
          resp_err      = lsu_err_q | mem_err_i;  // either part failing fails the access
          second_part_d = 1'b0;
          state_d       = LS_IDLE;
        end
      end

      LS_WAIT_RVALID_DONE: begin
        // first response of an overlapped pair
        if (mem_rvalid_i) begin
          lsu_err_d         = mem_err_i;
          ctrl.rdata_update = ~we_q;
          state_d           = LS_WAIT_RVALID;
        end
      end

      default: begin
        state_d = LS_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= LS_IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  // direction latched with the access attributes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      we_q <= we_i;
    end
  end

  assign ctrl.second_part = second_part_q;

  assign load_err_o  = resp_err & ~we_q;
  assign store_err_o = resp_err &  we_q;
  assign busy_o      = (state_q != LS_IDLE);

  ////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////

  // a response only arrives for a granted, still outstanding request
  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_rvalid_i |-> (state_q inside {LS_WAIT_RVALID, LS_WAIT_RVALID_MIS,
                                        LS_WAIT_RVALID_DONE}))
    else $error("memory response without outstanding request");

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_err_i |-> mem_rvalid_i)
    else $error("memory error outside a response");

endmodule

// File: logic/lsu_req_align.sv
// LSU request datapath
// word address, byte enables, rotated write data, split detection

`timescale 1ns/10ps

module lsu_req_align import lsu_types_pkg::*, mem_bus_pkg::*; (
  input  bus_word_t    addr_i,
  input  access_size_e size_i,
  input  bus_word_t    wdata_i,

  output bus_word_t    mem_addr_o,
  output be_t          mem_be_o,
  output bus_word_t    mem_wdata_o,

  lsu_ctrl_if.req      ctrl
);

  byte_offset_t offset;
  bus_word_t    word_addr;

  assign offset    = addr_i[1:0];
  assign word_addr = {addr_i[BUS_WIDTH-1:2], 2'b00};

  // upper word for the second part of a split access
  assign mem_addr_o = ctrl.second_part ? word_addr + bus_word_t'(WORD_STRIDE) : word_addr;

  assign ctrl.split_access = is_split(size_i, offset);

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    unique case (size_i)
      SIZE_WORD: begin
        if (!ctrl.second_part) begin
          mem_be_o = be_t'(4'b1111 << offset);  // lanes from offset upwards
        end else begin
          mem_be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, offset}));  // spill into next word
        end
      end
      SIZE_HALF: begin
        if (!ctrl.second_part) begin
          mem_be_o = be_t'(4'b0011 << offset);  // offset 3 keeps only lane 3
        end else begin
          mem_be_o = 4'b0001;  // upper byte of a half at offset 3
        end
      end
      default: begin
        mem_be_o = be_t'(4'b0001 << offset);  // either byte encoding
      end
    endcase
  end

  ////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////

  // rotate left by the byte offset so the second part reuses the same word
  always_comb begin
    unique case (offset)
      2'b00:   mem_wdata_o = wdata_i;
      2'b01:   mem_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   mem_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: mem_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // FSM must only select the second part for an access that really splits
  always_comb begin
    if (!$isunknown({size_i, offset, ctrl.second_part})) begin
      assert final (mem_be_o != '0)
        else $error("empty byte enables for size %0d offset %0d", size_i, offset);
    end
  end

endmodule

// File: logic/lsu_rdata_align.sv
// LSU response datapath
// captured access attributes, first-part byte store, load realignment and extension

`timescale 1ns/10ps

module lsu_rdata_align import lsu_types_pkg::*, mem_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  bus_word_t    addr_i,
  input  access_size_e size_i,
  input  logic         sign_ext_i,

  input  bus_word_t    mem_rdata_i,
  output bus_word_t    rdata_o,

  lsu_ctrl_if.rdata    ctrl
);

  byte_offset_t offset_q;
  access_size_e size_q;
  logic         sign_ext_q;
  logic [31:8]  rdata_q;      // upper bytes of the first response
  logic         split_q;      // access in flight spans two words
  bus_word_t    rdata_shift;  // addressed bytes moved down to lane 0
  logic         sign_bit;

  ////////////////////////////////////////
  // capture registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      offset_q   <= addr_i[1:0];
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // payload only, low byte never belongs to a split load
  always_ff @(posedge clk_i) begin
    if (ctrl.rdata_update) begin
      rdata_q <= mem_rdata_i[31:8];
    end
  end

  assign split_q = is_split(size_q, offset_q);

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // split: high bytes of first word below low bytes of second word
  always_comb begin
    unique case (offset_q)
      2'b00: rdata_shift = mem_rdata_i;  // never split
      2'b01: begin
        if (split_q) begin
          rdata_shift = {mem_rdata_i[7:0], rdata_q[31:8]};
        end else begin
          rdata_shift = {8'h00, mem_rdata_i[31:8]};
        end
      end
      2'b10: begin
        if (split_q) begin
          rdata_shift = {mem_rdata_i[15:0], rdata_q[31:16]};
        end else begin
          rdata_shift = {16'h0000, mem_rdata_i[31:16]};
        end
      end
      default: begin
        if (split_q) begin
          rdata_shift = {mem_rdata_i[23:0], rdata_q[31:24]};  // word or half at offset 3
        end else begin
          rdata_shift = {24'h00_0000, mem_rdata_i[31:24]};
        end
      end
    endcase
  end

  // zero or sign extension by size
  always_comb begin
    unique case (size_q)
      SIZE_WORD: begin
        sign_bit = 1'b0;
        rdata_o  = rdata_shift;
      end
      SIZE_HALF: begin
        sign_bit = sign_ext_q & rdata_shift[15];
        rdata_o  = {{16{sign_bit}}, rdata_shift[15:0]};
      end
      default: begin
        sign_bit = sign_ext_q & rdata_shift[7];  // byte
        rdata_o  = {{24{sign_bit}}, rdata_shift[7:0]};
      end
    endcase
  end

endmodule

// File: logic/load_store_unit.sv
// load/store unit top level
// FSM, request path and response path joined by the control interface

`timescale 1ns/10ps

module load_store_unit import lsu_types_pkg::*, mem_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  // execute stage side
  input  logic         req_i,
  input  bus_word_t    addr_i,
  input  logic         we_i,
  input  access_size_e size_i,
  input  logic         sign_ext_i,
  input  bus_word_t    wdata_i,
  output logic         valid_o,    // one-cycle completion pulse
  output bus_word_t    rdata_o,
  output logic         load_err_o,
  output logic         store_err_o,
  output logic         busy_o,

  // memory bus side
  output logic         mem_req_o,
  input  logic         mem_gnt_i,
  input  logic         mem_rvalid_i,
  input  logic         mem_err_i,
  output bus_word_t    mem_addr_o,
  output logic         mem_we_o,
  output be_t          mem_be_o,
  output bus_word_t    mem_wdata_o,
  input  bus_word_t    mem_rdata_i
);

  lsu_ctrl_if ctrl ();

  assign mem_we_o = we_i;  // core holds direction for the whole access

  lsu_fsm lsu_fsm_i (
    .clk_i,
    .rst_ni,
    .req_i,
    .we_i,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_err_i,
    .mem_req_o,
    .valid_o,
    .load_err_o,
    .store_err_o,
    .busy_o,
    .ctrl (ctrl.fsm)
  );

  lsu_req_align lsu_req_align_i (
    .addr_i,
    .size_i,
    .wdata_i,
    .mem_addr_o,
    .mem_be_o,
    .mem_wdata_o,
    .ctrl (ctrl.req)
  );

  lsu_rdata_align lsu_rdata_align_i (
    .clk_i,
    .rst_ni,
    .addr_i,
    .size_i,
    .sign_ext_i,
    .mem_rdata_i,
    .rdata_o,
    .ctrl (ctrl.rdata)
  );

endmodule

// File: testbench/tb_load_store_unit.sv
// testbench for the load/store unit
// LFSR stimulus, bus memory model with random grant and response delays,
// byte mirror reference model, checks and per-test report

`timescale 1ns/10ps

module tb_load_store_unit import lsu_types_pkg::*, mem_bus_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int WAIT_LIMIT = 50;   // cycles allowed for one access
  localparam int MEM_WORDS  = 64;

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  logic         we_i;
  logic         sign_ext_i;
  access_size_e size_i;
  bus_word_t    addr_i;
  bus_word_t    wdata_i;
  bus_word_t    rdata_o;
  logic         valid_o;
  logic         load_err_o;
  logic         store_err_o;
  logic         busy_o;
  logic         mem_req_o;
  logic         mem_gnt_i;
  logic         mem_rvalid_i;
  logic         mem_err_i;
  logic         mem_we_o;
  bus_word_t    mem_addr_o;
  bus_word_t    mem_wdata_o;
  bus_word_t    mem_rdata_i;
  be_t          mem_be_o;

  bus_word_t    mem_words [MEM_WORDS];  // bus side memory
  logic [7:0]   mirror [256];           // reference bytes in core byte order

  int           resp_due [$];   // cycle at which each response may go out
  bus_word_t    resp_data [$];
  logic         resp_err [$];
  int           cycle_cnt = 0;
  int           gnt_wait = 0;
  int           grant_cnt = 0;  // grants seen in the current access
  bus_word_t    grant_addr [2];
  logic         err_seen = 1'b0;
  logic         held_valid = 1'b0;
  bus_word_t    held_addr;
  be_t          held_be;
  int           overlap_cnt = 0;
  int           inj_err_cnt = 0;

  logic [31:0]  lfsr = 32'h9314_cc7f;
  int           errors = 0;
  int           check_cnt = 0;
  int           access_cnt = 0;
  int           test_cnt = 0;
  int           base_err;
  int           base_acc;
  logic         timed_out = 1'b0;

  load_store_unit load_store_unit_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 29) ^ 8'hc3;  // odd multiplier gives each byte address its own value
  endfunction

  // a word at a nonzero offset or a half at offset 3 crosses into the next word
  function automatic logic crosses_word(input logic [1:0] sz, input logic [1:0] off);
    return (sz == 2'b00 && off != 2'b00) || (sz == 2'b01 && off == 2'b11);
  endfunction

  function automatic bus_word_t expected_load(input bus_word_t a, input logic [1:0] sz,
                                              input logic sign);
    logic [7:0] loc;
    bus_word_t  raw;
    int         k;
    for (k = 0; k < 4; k++) begin
      loc            = a[7:0] + 8'(k);  // wraps like the 256-byte memory
      raw[8*k +: 8]  = mirror[loc];
    end
    case (sz)
      2'b00:   return raw;
      2'b01:   return {{16{sign & raw[15]}}, raw[15:0]};
      default: return {{24{sign & raw[7]}}, raw[7:0]};
    endcase
  endfunction

  task automatic mirror_store(input bus_word_t a, input logic [1:0] sz, input bus_word_t d);
    logic [7:0] loc;
    int         n;
    int         k;
    n = (sz == 2'b00) ? 4 : (sz == 2'b01) ? 2 : 1;
    for (k = 0; k < n; k++) begin
      loc         = a[7:0] + 8'(k);
      mirror[loc] = d[8*k +: 8];
    end
  endtask

  task automatic check_value(input string name, input bus_word_t got, input bus_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_value("mem_req_o", 32'(mem_req_o), 32'd0);
    check_value("valid_o", 32'(valid_o), 32'd0);
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("load_err_o", 32'(load_err_o), 32'd0);
    check_value("store_err_o", 32'(store_err_o), 32'd0);
  endtask

  task automatic start_test();
    base_err = errors;
    base_acc = access_cnt;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %s: %0d accesses, %0d errors", name, access_cnt - base_acc,
             errors - base_err);
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // drives on the falling edge and samples a quarter period later
  initial begin : memory_model
    bus_word_t word;
    logic      err;
    int        w;
    int        b;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_err_i    = 1'b0;
    mem_rdata_i  = '0;
    for (w = 0; w < MEM_WORDS; w++) begin
      mem_words[w] = {fill_byte(4*w + 3), fill_byte(4*w + 2), fill_byte(4*w + 1),
                      fill_byte(4*w)};
    end
    forever begin
      @(negedge clk_i);
      cycle_cnt++;
      if (resp_due.size() > 0 && resp_due[0] <= cycle_cnt) begin  // in order only
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = resp_data.pop_front();
        mem_err_i    = resp_err.pop_front();
        resp_due.delete(0);
      end else begin
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_err_i    = 1'b0;
      end
      mem_gnt_i = (gnt_wait == 0);  // grant without a request is ignored
      #(CLK_PERIOD / 4);
      if (rst_ni && mem_req_o) begin
        if (held_valid) begin  // back-pressure keeps the request still
          check_value("held mem_addr_o", mem_addr_o, held_addr);
          check_value("held mem_be_o", 32'(mem_be_o), 32'(held_be));
        end
        if (mem_gnt_i) begin
          if (resp_due.size() >= 2) begin
            $display("more than two bus transactions outstanding at %0t ns", $time);
            errors++;
          end
          if (resp_due.size() > 0) begin
            overlap_cnt++;  // granted before the earlier response
          end
          word = mem_words[mem_addr_o[7:2]];
          if (mem_we_o) begin
            for (b = 0; b < BYTES_PER_WORD; b++) begin
              if (mem_be_o[b]) begin
                mem_words[mem_addr_o[7:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
              end
            end
          end
          err = (rand_bits(4) == 0);  // about one in sixteen
          resp_due.push_back(cycle_cnt + 1 + int'(rand_bits(2) % 3));
          resp_data.push_back(word);
          resp_err.push_back(err);
          if (grant_cnt < 2) begin
            grant_addr[grant_cnt] = mem_addr_o;
          end
          grant_cnt++;
          err_seen   = err_seen | err;
          inj_err_cnt += int'(err);
          held_valid = 1'b0;
          gnt_wait   = int'(rand_bits(2));
        end else begin
          held_valid = 1'b1;
          held_addr  = mem_addr_o;
          held_be    = mem_be_o;
          gnt_wait--;
        end
      end else if (held_valid) begin
        $display("mem_req_o dropped before its grant at %0t ns", $time);
        errors++;
        held_valid = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // access sequencing
  ////////////////////////////////////////

  // starts and ends on a falling edge
  task automatic run_access(input logic we, input logic [1:0] sz, input bus_word_t a,
                            input logic sign, input bus_word_t d);
    bus_word_t exp_data;
    bus_word_t got_data;
    bus_word_t word_a;
    logic      got_lerr;
    logic      got_serr;
    logic      got_busy;
    logic      split;
    logic      done;
    int        cycles;
    if (!timed_out) begin
      split      = crosses_word(sz, a[1:0]);
      exp_data   = expected_load(a, sz, sign);
      word_a     = {a[31:2], 2'b00};
      grant_cnt  = 0;
      err_seen   = 1'b0;
      req_i      = 1'b1;
      we_i       = we;
      size_i     = access_size_e'(sz);  // 2'b11 is the second byte code
      addr_i     = a;
      sign_ext_i = sign;
      wdata_i    = d;
      access_cnt++;
      got_data   = '0;
      got_lerr   = 1'b0;
      got_serr   = 1'b0;
      got_busy   = 1'b0;
      done       = 1'b0;
      cycles     = 0;
      while (!done && cycles < WAIT_LIMIT) begin
        #(CLK_PERIOD / 4);
        if (valid_o) begin
          got_data = rdata_o;
          got_lerr = load_err_o;
          got_serr = store_err_o;
          got_busy = busy_o;
          done     = 1'b1;
        end else begin
          @(negedge clk_i);
          cycles++;
        end
      end
      if (!done) begin
        $display("timeout: no valid_o within %0d cycles for a %s at address %h",
                 WAIT_LIMIT, we ? "store" : "load", a);
        timed_out = 1'b1;
      end else begin
        @(negedge clk_i);
        req_i = 1'b0;
        if (!we) begin
          check_value("rdata_o", got_data, exp_data);
        end else begin
          mirror_store(a, sz, d);
        end
        check_value("load_err_o", 32'(got_lerr), 32'(err_seen & ~we));
        check_value("store_err_o", 32'(got_serr), 32'(err_seen & we));
        check_value("busy_o", 32'(got_busy), 32'd1);  // access still in flight at completion
        check_value("bus transactions", grant_cnt, split ? 2 : 1);
        check_value("first mem_addr_o", grant_addr[0], word_a);
        if (split) begin
          check_value("second mem_addr_o", grant_addr[1], word_a + 32'd4);
        end
        #(CLK_PERIOD / 4);
        check_idle();  // valid_o must not pulse again
        @(negedge clk_i);
      end
    end
  endtask

  // word loads over every word that a store touched
  task automatic check_words(input bus_word_t a, input logic [1:0] sz);
    run_access(1'b0, 2'b00, {a[31:2], 2'b00}, 1'b0, '0);
    if (crosses_word(sz, a[1:0])) begin
      run_access(1'b0, 2'b00, {a[31:2], 2'b00} + 32'd4, 1'b0, '0);
    end
  endtask

  task automatic idle_cycles(input int n);
    int i;
    for (i = 0; i < n && !timed_out; i++) begin
      #(CLK_PERIOD / 4);
      check_idle();
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin : stimulus
    bus_word_t  a;
    bus_word_t  d;
    logic [1:0] sz;
    int         i;
    int         s;
    int         off;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    size_i     = SIZE_WORD;
    addr_i     = '0;
    sign_ext_i = 1'b0;
    wdata_i    = '0;
    for (i = 0; i < 256; i++) begin
      mirror[i] = fill_byte(i);
    end

    start_test();
    repeat (2) @(negedge clk_i);
    #(CLK_PERIOD / 4);
    check_idle();  // still in reset
    @(negedge clk_i);
    rst_ni = 1'b1;  // three rising edges under reset
    #(CLK_PERIOD / 4);
    check_idle();
    @(negedge clk_i);
    finish_test("reset");

    start_test();
    for (i = 0; i < 40; i++) begin
      sz = 2'(rand_bits(2));
      a  = rand_bits(8);
      if (sz == 2'b00) begin
        a[1:0] = 2'b00;
      end else if (sz == 2'b01) begin
        a[0] = 1'b0;
      end
      run_access(1'b0, sz, a, 1'(rand_bits(1)), '0);
    end
    finish_test("aligned loads");

    start_test();
    for (s = 0; s < 4; s++) begin  // both byte codes included
      for (off = 0; off < 4; off++) begin
        a      = rand_bits(8);
        a[1:0] = 2'(off);
        d      = rand_bits(32);
        run_access(1'b1, 2'(s), a, 1'b0, d);
        check_words(a, 2'(s));
      end
    end
    finish_test("stores");

    start_test();
    for (off = 1; off < 4; off++) begin
      a      = rand_bits(8);
      a[1:0] = 2'(off);
      run_access(1'b0, 2'b00, a, 1'b0, '0);
      d = rand_bits(32);
      run_access(1'b1, 2'b00, a, 1'b0, d);
      check_words(a, 2'b00);
    end
    a      = rand_bits(8);
    a[1:0] = 2'b11;
    run_access(1'b0, 2'b01, a, 1'b1, '0);
    d = rand_bits(32);
    run_access(1'b1, 2'b01, a, 1'b0, d);
    check_words(a, 2'b01);
    finish_test("split accesses");

    start_test();
    for (i = 0; i < 150; i++) begin
      sz = 2'(rand_bits(2));
      a  = rand_bits(8);
      d  = rand_bits(32);
      run_access(1'(rand_bits(1)), sz, a, 1'(rand_bits(1)), d);
      idle_cycles(int'(rand_bits(2)));
    end
    finish_test("random mix");

    start_test();
    for (i = 0; i < MEM_WORDS; i++) begin
      run_access(1'b0, 2'b00, 32'(4 * i), 1'b0, '0);
    end
    finish_test("memory sweep");

    if (!timed_out && overlap_cnt == 0) begin
      $display("no second grant arrived before a first response");
      errors++;
    end
    if (!timed_out && inj_err_cnt == 0) begin
      $display("no bus error was injected");
      errors++;
    end
    $display("totals: %0d tests, %0d accesses, %0d checks, %0d errors, %0d overlaps, %0d bus errors",
             test_cnt, access_cnt, check_cnt, errors, overlap_cnt, inj_err_cnt);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
logic/lsu_types_pkg.sv
logic/mem_bus_pkg.sv
logic/lsu_ctrl_if.sv
logic/lsu_fsm.sv
logic/lsu_req_align.sv
logic/lsu_rdata_align.sv
logic/load_store_unit.sv
testbench/tb_load_store_unit.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_load_store_unit
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), decide pass or fail from $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test target: run passed"; \
	else \
		echo "test target: run failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
